//--- common/i2c_target_pkg.sv
// shared constants, register map and state types for the I2C target, referenced by scoped name
package i2c_target_pkg;

    // bus and filter
    localparam logic [6:0] TARGET_ADDR  = 7'h28;
    localparam int         DEBOUNCE_LEN = 10;

    // data path widths
    localparam int DATA_W      = 8;
    localparam int REG_ADDR_W  = 8;
    localparam int WORD_W      = 16;
    localparam int RAM_WORDS   = 4;
    localparam int HOST_ADDR_W = 3;

    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [HOST_ADDR_W-1:0] host_addr_t;

    // read/write words after reset
    localparam word_t RAM_RESET_0 = 16'h8095;
    localparam word_t RAM_RESET_1 = 16'h031D;
    localparam word_t RAM_RESET_2 = 16'h0000;
    localparam word_t RAM_RESET_3 = 16'h0000;

    // read-only bytes, mapped from RO_BASE_ADDR upwards
    localparam data_t RO_VALUE_0 = 8'h10;
    localparam data_t RO_VALUE_1 = 8'h20;
    localparam data_t RO_VALUE_2 = 8'h30;
    localparam data_t RO_VALUE_3 = 8'h40;

    localparam reg_addr_t RO_BASE_ADDR = 8'h08;

    // returned for any unmapped register address
    localparam data_t INVALID_READ = 8'hFF;

    // STARTs seen since the last STOP saturate here
    localparam logic [1:0] START_CNT_MAX = 2'd2;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_CTRL,
        ST_REG_ADDR,
        ST_WRITE,
        ST_READ,
        ST_STOP
    } engine_state_t;

    // sub-state of one received byte
    typedef enum logic [1:0]
    {
        PH_BITS,
        PH_ACK,
        PH_DONE
    } byte_phase_t;

endpackage

//--- common/bus_event_if.sv
// filtered SCL/SDA events passed from the line filter to the transfer engine
interface bus_event_if;

    // one-cycle pulses on debounced SCL edges
    logic       scl_rise;
    logic       scl_fall;
    // debounced SDA level
    logic       sda_level;
    // bus conditions, one-cycle pulses
    logic       start_pulse;
    logic       stop_pulse;
    // STARTs since the last STOP, saturating
    logic [1:0] start_count;

    modport filter
    (
        output scl_rise, scl_fall, sda_level, start_pulse, stop_pulse, start_count
    );

    modport engine
    (
        input scl_rise, scl_fall, sda_level, start_pulse, stop_pulse, start_count
    );

endinterface

//--- common/reg_access_if.sv
// register read and write strobes between the transfer engine and the register bank
interface reg_access_if;

    // single-cycle strobes, never high together
    logic                      rd_strobe;
    logic                      wr_strobe;
    i2c_target_pkg::reg_addr_t reg_addr;
    i2c_target_pkg::data_t     wr_data;
    // valid the cycle after rd_strobe
    i2c_target_pkg::data_t     rd_data;

    modport engine
    (
        output rd_strobe, wr_strobe, reg_addr, wr_data,
        input  rd_data
    );

    modport bank
    (
        input  rd_strobe, wr_strobe, reg_addr, wr_data,
        output rd_data
    );

endinterface

//--- design/i2c_line_filter.sv
// debounces the SCL and SDA pins and turns them into edge, START and STOP events
module i2c_line_filter
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic        scl,
    input  logic        sda_in,
    bus_event_if.filter events
);

    logic [i2c_target_pkg::DEBOUNCE_LEN-1:0] scl_pipe;
    logic [i2c_target_pkg::DEBOUNCE_LEN-1:0] sda_pipe;
    logic scl_deb;
    logic sda_deb;
    logic scl_deb_q;
    logic sda_deb_q;
    logic scl_high;
    logic sda_fall;
    logic sda_rise;
    logic start_det;
    logic stop_det;

    // new level only once the older samples all agree, else keep the old one
    function automatic logic settle
    (
        input logic [i2c_target_pkg::DEBOUNCE_LEN-1:0] pipe,
        input logic                                    level
    );
        if (&pipe[i2c_target_pkg::DEBOUNCE_LEN-1:1])
            return 1'b1;
        if (~|pipe[i2c_target_pkg::DEBOUNCE_LEN-1:1])
            return 1'b0;
        return level;
    endfunction

    assign events.scl_rise  = scl_deb & ~scl_deb_q;
    assign events.scl_fall  = ~scl_deb & scl_deb_q;
    assign events.sda_level = sda_deb;

    // SDA may only move while SCL is low, except for START and STOP
    assign scl_high  = scl_deb & scl_deb_q;
    assign sda_fall  = ~sda_deb & sda_deb_q;
    assign sda_rise  = sda_deb & ~sda_deb_q;
    assign start_det = scl_high & sda_fall;
    assign stop_det  = scl_high & sda_rise;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            // idle bus has both lines pulled high
            scl_pipe           <= '1;
            sda_pipe           <= '1;
            scl_deb            <= 1'b1;
            sda_deb            <= 1'b1;
            scl_deb_q          <= 1'b1;
            sda_deb_q          <= 1'b1;
            events.start_pulse <= 1'b0;
            events.stop_pulse  <= 1'b0;
            events.start_count <= 2'd0;
        end
        else
        begin
            scl_pipe  <= {scl_pipe[i2c_target_pkg::DEBOUNCE_LEN-2:0], scl};
            sda_pipe  <= {sda_pipe[i2c_target_pkg::DEBOUNCE_LEN-2:0], sda_in};
            scl_deb   <= settle(scl_pipe, scl_deb);
            sda_deb   <= settle(sda_pipe, sda_deb);
            scl_deb_q <= scl_deb;
            sda_deb_q <= sda_deb;

            events.start_pulse <= start_det;
            events.stop_pulse  <= stop_det;

            if (start_det)
            begin
                if (events.start_count != i2c_target_pkg::START_CNT_MAX)
                    events.start_count <= events.start_count + 2'd1;
            end
            else if (stop_det)
                events.start_count <= 2'd0;
        end
    end

    a_start_stop_exclusive : assert property (@(posedge CLOCK) disable iff (RESET)
        !(events.start_pulse && events.stop_pulse));

endmodule

//--- protocol/i2c_transfer_engine.sv
// byte-level I2C target FSM: shifts bytes in and out, drives ACK, issues register accesses
module i2c_transfer_engine
(
    input  logic         CLOCK,
    input  logic         RESET,
    bus_event_if.engine  events,
    reg_access_if.engine regs,
    output logic         sda_out,
    output logic         sda_oe
);

    i2c_target_pkg::engine_state_t state;
    i2c_target_pkg::byte_phase_t   phase;
    logic [2:0]                    bit_cnt;
    i2c_target_pkg::data_t         rx_shift;
    i2c_target_pkg::data_t         rx_next;
    i2c_target_pkg::data_t         tx_shift;
    i2c_target_pkg::reg_addr_t     reg_addr;
    logic                          is_read;
    logic                          rd_load;
    logic                          rx_sample;
    logic                          rx_state;

    assign rx_state = (state == i2c_target_pkg::ST_CTRL) ||
                      (state == i2c_target_pkg::ST_REG_ADDR) ||
                      (state == i2c_target_pkg::ST_WRITE);
    assign rx_sample = rx_state && (phase == i2c_target_pkg::PH_BITS) && events.scl_rise;
    assign rx_next   = {rx_shift[i2c_target_pkg::DATA_W-2:0], events.sda_level};

    assign regs.reg_addr = reg_addr;
    assign regs.wr_data  = rx_shift;

    // only the read byte is driven from the shifter, ACK is always low
    assign sda_out = (state == i2c_target_pkg::ST_READ) ? tx_shift[i2c_target_pkg::DATA_W-1]
                                                        : 1'b0;

    always_ff @(posedge CLOCK)
    begin
        if (rd_load)
            tx_shift <= regs.rd_data;
        else if ((state == i2c_target_pkg::ST_READ) && events.scl_fall)
            tx_shift <= {tx_shift[i2c_target_pkg::DATA_W-2:0], 1'b0};

        if (rx_sample)
            rx_shift <= rx_next;
    end

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state          <= i2c_target_pkg::ST_IDLE;
            phase          <= i2c_target_pkg::PH_BITS;
            bit_cnt        <= 3'd0;
            reg_addr       <= '0;
            is_read        <= 1'b0;
            rd_load        <= 1'b0;
            regs.rd_strobe <= 1'b0;
            regs.wr_strobe <= 1'b0;
            sda_oe         <= 1'b0;
        end
        else
        begin
            regs.rd_strobe <= 1'b0;
            regs.wr_strobe <= 1'b0;
            // bank data is ready one cycle after the strobe
            rd_load        <= regs.rd_strobe;

            case (state)
            i2c_target_pkg::ST_IDLE:
            begin
                if (events.start_pulse)
                begin
                    state   <= i2c_target_pkg::ST_CTRL;
                    phase   <= i2c_target_pkg::PH_BITS;
                    bit_cnt <= 3'd0;
                    is_read <= 1'b0;
                end
            end

            i2c_target_pkg::ST_CTRL, i2c_target_pkg::ST_REG_ADDR, i2c_target_pkg::ST_WRITE:
            begin
                if ((state == i2c_target_pkg::ST_WRITE) && events.start_pulse &&
                    (events.start_count == i2c_target_pkg::START_CNT_MAX))
                begin
                    // repeated START instead of a data byte
                    state   <= i2c_target_pkg::ST_CTRL;
                    phase   <= i2c_target_pkg::PH_BITS;
                    bit_cnt <= 3'd0;
                end
                else
                begin
                    case (phase)
                    i2c_target_pkg::PH_BITS:
                    begin
                        if (events.scl_rise)
                        begin
                            // wraps back to zero after the last bit
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                phase <= i2c_target_pkg::PH_ACK;
                                if ((state == i2c_target_pkg::ST_CTRL) &&
                                    (rx_next[i2c_target_pkg::DATA_W-1:1] !=
                                     i2c_target_pkg::TARGET_ADDR))
                                    state <= i2c_target_pkg::ST_IDLE;
                                else if ((state == i2c_target_pkg::ST_CTRL) && rx_next[0])
                                begin
                                    // fetch early so the byte is ready when ACK ends
                                    is_read        <= 1'b1;
                                    regs.rd_strobe <= 1'b1;
                                end
                            end
                        end
                    end

                    i2c_target_pkg::PH_ACK:
                    begin
                        if (events.scl_fall)
                        begin
                            if (!sda_oe)
                                sda_oe <= 1'b1;
                            else if (is_read)
                                state <= i2c_target_pkg::ST_READ;
                            else
                            begin
                                sda_oe <= 1'b0;
                                phase  <= i2c_target_pkg::PH_DONE;
                            end
                        end
                    end

                    default:
                    begin
                        phase <= i2c_target_pkg::PH_BITS;
                        case (state)
                        i2c_target_pkg::ST_CTRL:
                            state <= i2c_target_pkg::ST_REG_ADDR;
                        i2c_target_pkg::ST_REG_ADDR:
                        begin
                            reg_addr <= rx_shift;
                            state    <= i2c_target_pkg::ST_WRITE;
                        end
                        default:
                        begin
                            // one data byte per write, the rest go unacknowledged
                            regs.wr_strobe <= 1'b1;
                            state          <= i2c_target_pkg::ST_STOP;
                        end
                        endcase
                    end
                    endcase
                end
            end

            i2c_target_pkg::ST_READ:
            begin
                // master ACK after the byte is not sampled
                if (events.scl_fall)
                begin
                    if (bit_cnt == 3'd7)
                    begin
                        sda_oe <= 1'b0;
                        state  <= i2c_target_pkg::ST_STOP;
                    end
                    else
                        bit_cnt <= bit_cnt + 3'd1;
                end
            end

            i2c_target_pkg::ST_STOP:
                reg_addr <= '0;

            default:
                state <= i2c_target_pkg::ST_IDLE;
            endcase

            if (events.stop_pulse)
            begin
                state   <= i2c_target_pkg::ST_IDLE;
                phase   <= i2c_target_pkg::PH_BITS;
                bit_cnt <= 3'd0;
                sda_oe  <= 1'b0;
            end
        end
    end

    a_idle_released : assert property (@(posedge CLOCK) disable iff (RESET)
        (state == i2c_target_pkg::ST_IDLE) |-> !sda_oe);

    a_strobes_exclusive : assert property (@(posedge CLOCK) disable iff (RESET)
        !(regs.rd_strobe && regs.wr_strobe));

endmodule

//--- design/register_bank.sv
// register file behind the I2C target, with byte access from the bus and a host word port
module register_bank
(
    input  logic                       CLOCK,
    input  logic                       RESET,
    reg_access_if.bank                 regs,
    input  logic                       rd_en,
    input  i2c_target_pkg::host_addr_t add_in,
    output i2c_target_pkg::word_t      dat_out
);

    i2c_target_pkg::word_t        ram [i2c_target_pkg::RAM_WORDS];
    i2c_target_pkg::reg_addr_t    ro_off;
    logic                         in_ram;

    // bytes 0x00..0x07, high byte of each word at the even address
    assign in_ram = regs.reg_addr < i2c_target_pkg::RO_BASE_ADDR;
    assign ro_off = regs.reg_addr - i2c_target_pkg::RO_BASE_ADDR;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            ram[0] <= i2c_target_pkg::RAM_RESET_0;
            ram[1] <= i2c_target_pkg::RAM_RESET_1;
            ram[2] <= i2c_target_pkg::RAM_RESET_2;
            ram[3] <= i2c_target_pkg::RAM_RESET_3;
        end
        else if (regs.wr_strobe && in_ram)
        begin
            if (regs.reg_addr[0])
                ram[regs.reg_addr[2:1]][i2c_target_pkg::DATA_W-1:0] <= regs.wr_data;
            else
                ram[regs.reg_addr[2:1]][i2c_target_pkg::WORD_W-1:i2c_target_pkg::DATA_W]
                    <= regs.wr_data;
        end
    end

    // I2C side byte read
    always_ff @(posedge CLOCK)
    begin
        if (regs.rd_strobe)
        begin
            if (in_ram)
            begin
                if (regs.reg_addr[0])
                    regs.rd_data <= ram[regs.reg_addr[2:1]][i2c_target_pkg::DATA_W-1:0];
                else
                    regs.rd_data <= ram[regs.reg_addr[2:1]]
                                       [i2c_target_pkg::WORD_W-1:i2c_target_pkg::DATA_W];
            end
            else if (ro_off < 8'd4)
            begin
                // read-only bytes come straight from the map constants
                case (ro_off[1:0])
                2'd0:    regs.rd_data <= i2c_target_pkg::RO_VALUE_0;
                2'd1:    regs.rd_data <= i2c_target_pkg::RO_VALUE_1;
                2'd2:    regs.rd_data <= i2c_target_pkg::RO_VALUE_2;
                default: regs.rd_data <= i2c_target_pkg::RO_VALUE_3;
                endcase
            end
            else
                regs.rd_data <= i2c_target_pkg::INVALID_READ;
        end
    end

    // host word port, holds between reads
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
            dat_out <= '0;
        else if (rd_en)
        begin
            if (add_in < i2c_target_pkg::host_addr_t'(i2c_target_pkg::RAM_WORDS))
                dat_out <= ram[add_in[1:0]];
            else
                dat_out <= '0;
        end
    end

    // writes outside 0x00..0x07 leave every word untouched
    a_ro_untouched : assert property (@(posedge CLOCK) disable iff (RESET)
        (regs.wr_strobe && !in_ram) |=>
            ($stable(ram[0]) && $stable(ram[1]) && $stable(ram[2]) && $stable(ram[3])));

endmodule

//--- design/i2c_target_top.sv
// top level of the I2C target, connects line filter, transfer engine and register bank
module i2c_target_top
(
    input  logic                       CLOCK,
    input  logic                       RESET,
    input  logic                       scl,
    input  logic                       sda_in,
    output logic                       sda_out,
    output logic                       sda_oe,
    input  logic                       rd_en,
    input  i2c_target_pkg::host_addr_t add_in,
    output i2c_target_pkg::word_t      dat_out
);

    bus_event_if  bus_events ();
    reg_access_if reg_access ();

    i2c_line_filter i2c_line_filter_inst
    (
        .CLOCK  (CLOCK),
        .RESET  (RESET),
        .scl    (scl),
        .sda_in (sda_in),
        .events (bus_events.filter)
    );

    // drives SDA only through sda_oe, the bus itself is open drain outside
    i2c_transfer_engine i2c_transfer_engine_inst
    (
        .CLOCK   (CLOCK),
        .RESET   (RESET),
        .events  (bus_events.engine),
        .regs    (reg_access.engine),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

    register_bank register_bank_inst
    (
        .CLOCK   (CLOCK),
        .RESET   (RESET),
        .regs    (reg_access.bank),
        .rd_en   (rd_en),
        .add_in  (add_in),
        .dat_out (dat_out)
    );

endmodule

//--- test/tb_i2c_target.sv
// directed testbench for the I2C target, runs a bus master model against i2c_target_top
module tb_i2c_target;

    // the whole bus time of all tests stays well below this
    localparam int TIMEOUT_CYCLES = 40000;
    // half of one SCL phase, in clock cycles
    localparam int HALF_PHASE = 20;
    localparam i2c_target_pkg::data_t CTRL_WRITE = {i2c_target_pkg::TARGET_ADDR, 1'b0};
    localparam i2c_target_pkg::data_t CTRL_READ  = {i2c_target_pkg::TARGET_ADDR, 1'b1};

    logic                       CLOCK;
    logic                       RESET;
    logic                       scl_drv;
    logic                       sda_drv;
    logic                       sda_bus;
    logic                       sda_out;
    logic                       sda_oe;
    logic                       rd_en;
    i2c_target_pkg::host_addr_t add_in;
    i2c_target_pkg::word_t      dat_out;

    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_errors = 0;
    int test_count  = 0;

    // open drain SDA, the target can only pull the line low
    assign sda_bus = sda_drv & (sda_oe ? sda_out : 1'b1);

    i2c_target_top i2c_target_top_inst
    (
        .CLOCK   (CLOCK),
        .RESET   (RESET),
        .scl     (scl_drv),
        .sda_in  (sda_bus),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .rd_en   (rd_en),
        .add_in  (add_in),
        .dat_out (dat_out)
    );

    initial
    begin
        CLOCK = 1'b0;
        forever #10 CLOCK = ~CLOCK;
    end

    always @(posedge CLOCK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // inputs change 2 units after the rising edge
    task automatic tick(input int cycles);
        repeat (cycles) @(posedge CLOCK);
        #2;
    endtask

    task automatic check_byte(input string name, input i2c_target_pkg::data_t expected,
                              input i2c_target_pkg::data_t actual);
        check_count = check_count + 1;
        if (actual !== expected)
        begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input i2c_target_pkg::word_t expected,
                              input i2c_target_pkg::word_t actual);
        check_count = check_count + 1;
        if (actual !== expected)
        begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_ack(input string name, input logic expected, input logic actual);
        check_count = check_count + 1;
        if (actual !== expected)
        begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // one SCL clock, SDA set mid low phase, line sampled mid high phase
    task automatic clock_bit(input logic value, output logic level);
        tick(HALF_PHASE);
        sda_drv = value;
        tick(HALF_PHASE);
        scl_drv = 1'b1;
        tick(HALF_PHASE);
        level = sda_bus;
        tick(HALF_PHASE);
        scl_drv = 1'b0;
    endtask

    task automatic start_cond();
        tick(HALF_PHASE);
        sda_drv = 1'b1;
        tick(HALF_PHASE);
        scl_drv = 1'b1;
        tick(2 * HALF_PHASE);
        sda_drv = 1'b0;
        tick(2 * HALF_PHASE);
        scl_drv = 1'b0;
    endtask

    task automatic stop_cond();
        tick(HALF_PHASE);
        sda_drv = 1'b0;
        tick(HALF_PHASE);
        scl_drv = 1'b1;
        tick(2 * HALF_PHASE);
        sda_drv = 1'b1;
        tick(2 * HALF_PHASE);
    endtask

    // ack is the line level in the ninth clock, low means acknowledged
    task automatic send_byte(input i2c_target_pkg::data_t value, output logic ack);
        logic level;
        for (int i = i2c_target_pkg::DATA_W - 1; i >= 0; i--)
            clock_bit(value[i], level);
        clock_bit(1'b1, ack);
    endtask

    task automatic recv_byte(output i2c_target_pkg::data_t value);
        logic level;
        value = '0;
        for (int i = 0; i < i2c_target_pkg::DATA_W; i++)
        begin
            clock_bit(1'b1, level);
            value = {value[i2c_target_pkg::DATA_W-2:0], level};
        end
        // master NACK ends the read
        clock_bit(1'b1, level);
    endtask

    task automatic write_reg(input string name, input i2c_target_pkg::reg_addr_t addr,
                             input i2c_target_pkg::data_t data);
        logic ack;
        start_cond();
        send_byte(CTRL_WRITE, ack);
        check_ack({name, " control ack"}, 1'b0, ack);
        send_byte(addr, ack);
        check_ack({name, " address ack"}, 1'b0, ack);
        send_byte(data, ack);
        check_ack({name, " data ack"}, 1'b0, ack);
        stop_cond();
    endtask

    // register address by write, then repeated START and a one-byte read
    task automatic read_reg(input string name, input i2c_target_pkg::reg_addr_t addr,
                            output i2c_target_pkg::data_t value);
        logic ack;
        start_cond();
        send_byte(CTRL_WRITE, ack);
        check_ack({name, " control ack"}, 1'b0, ack);
        send_byte(addr, ack);
        check_ack({name, " address ack"}, 1'b0, ack);
        start_cond();
        send_byte(CTRL_READ, ack);
        check_ack({name, " read control ack"}, 1'b0, ack);
        recv_byte(value);
        stop_cond();
    endtask

    task automatic host_read(input i2c_target_pkg::host_addr_t addr,
                             output i2c_target_pkg::word_t value);
        add_in = addr;
        rd_en  = 1'b1;
        tick(1);
        rd_en  = 1'b0;
        value  = dat_out;
    endtask

    task automatic finish_test(input string name);
        test_count = test_count + 1;
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic reset_values();
        i2c_target_pkg::word_t word;
        check_ack("sda_oe after reset", 1'b0, sda_oe);
        check_word("dat_out after reset", 16'h0000, dat_out);
        host_read(3'd0, word);
        check_word("host word 0", 16'h8095, word);
        host_read(3'd1, word);
        check_word("host word 1", 16'h031D, word);
        host_read(3'd5, word);
        check_word("host address 5", 16'h0000, word);
        finish_test("reset_values");
    endtask

    task automatic write_one_byte();
        i2c_target_pkg::word_t word;
        write_reg("write 0x02", 8'h02, 8'hA5);
        // even address holds the high byte
        host_read(3'd1, word);
        check_word("host word 1 after write", 16'hA51D, word);
        finish_test("write_one_byte");
    endtask

    task automatic read_after_restart();
        i2c_target_pkg::data_t value;
        read_reg("read 0x09", 8'h09, value);
        check_byte("read 0x09", 8'h20, value);
        read_reg("read 0x20", 8'h20, value);
        check_byte("read 0x20", 8'hFF, value);
        finish_test("read_after_restart");
    endtask

    task automatic ignore_wrong_address();
        logic                  ack;
        i2c_target_pkg::word_t word;
        start_cond();
        send_byte(8'h52, ack);
        check_ack("control 0x52 not acknowledged", 1'b1, ack);
        stop_cond();
        host_read(3'd0, word);
        check_word("host word 0 after wrong address", 16'h8095, word);
        finish_test("ignore_wrong_address");
    endtask

    task automatic read_only_and_cleared_addr();
        logic                  ack;
        i2c_target_pkg::data_t value;
        write_reg("write 0x08", 8'h08, 8'h55);
        read_reg("read 0x08", 8'h08, value);
        check_byte("read 0x08 after write", 8'h10, value);
        // address went back to zero at the end of the last transfer
        start_cond();
        send_byte(CTRL_READ, ack);
        check_ack("plain read control ack", 1'b0, ack);
        recv_byte(value);
        stop_cond();
        check_byte("read after stop", 8'h80, value);
        finish_test("read_only_and_cleared_addr");
    endtask

    initial
    begin
        RESET   = 1'b1;
        scl_drv = 1'b1;
        sda_drv = 1'b1;
        rd_en   = 1'b0;
        add_in  = '0;
        repeat (4) @(posedge CLOCK);
        #2;
        RESET = 1'b0;
        tick(2);

        reset_values();
        write_one_byte();
        read_after_restart();
        ignore_wrong_address();
        read_only_and_cleared_addr();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- vlog.f
common/i2c_target_pkg.sv
common/bus_event_if.sv
common/reg_access_if.sv
design/i2c_line_filter.sv
protocol/i2c_transfer_engine.sv
design/register_bank.sv
design/i2c_target_top.sv
test/tb_i2c_target.sv

//--- run_sim.sh
#!/bin/sh
# compile the I2C target testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_i2c_target -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile step returned status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_i2c_target)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
